/* include/cpu_consts.svh */
// cpu constants
// sizes shared by the pipeline packages and RTL

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_XLEN        32  // data and instruction width
`define CPU_NREGS       32  // architectural registers

// word counts, both memories are word addressed
`define CPU_IMEM_DEPTH  64
`define CPU_DMEM_DEPTH  64

`endif

/* source/cpu_isa_pkg.sv */
// cpu_isa_pkg
// instruction set encodings for the supported MIPS subset

`default_nettype none

package cpu_isa_pkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0]
    {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    // rs, rt and rd fields are all 5 bits
    typedef logic [4:0] reg_idx_t;

endpackage

`default_nettype wire

/* source/cpu_pipe_pkg.sv */
// cpu_pipe_pkg
// control bundle and stage register layouts of the pipeline

`default_nettype none

package cpu_pipe_pkg;

    `include "cpu_consts.svh"

    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,  // all-zero control decodes to add
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // operand source chosen in execute
    typedef enum logic [1:0]
    {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef struct packed
    {
        logic    reg_write;    // writes a register
        logic    mem_to_reg;   // load data to write-back
        logic    mem_write;
        logic    alu_src_imm;  // operand b from immediate
        logic    uses_rt;      // rt is a real source
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed
    {
        ctrl_t                  ctrl;
        cpu_isa_pkg::reg_idx_t  rs;
        cpu_isa_pkg::reg_idx_t  rt;
        cpu_isa_pkg::reg_idx_t  rd;        // destination, rd or rt
        logic [`CPU_XLEN-1:0]   rs_value;
        logic [`CPU_XLEN-1:0]   rt_value;
        logic [`CPU_XLEN-1:0]   imm;       // sign extended
    } id_ex_t;

    typedef struct packed
    {
        ctrl_t                  ctrl;
        cpu_isa_pkg::reg_idx_t  rd;
        logic [`CPU_XLEN-1:0]   alu_result;
        logic [`CPU_XLEN-1:0]   store_data;
    } ex_mem_t;

endpackage

`default_nettype wire

/* source/fwd_if.sv */
// fwd_if
// memory and write-back results offered back to execute and the register file

`timescale 1ns/10ps
`default_nettype none

`include "cpu_consts.svh"

interface fwd_if;

    cpu_isa_pkg::reg_idx_t  mem_rd;
    logic                   mem_reg_write;
    logic                   mem_is_load;   // value not ready yet in memory stage
    logic [`CPU_XLEN-1:0]   mem_value;
    cpu_isa_pkg::reg_idx_t  wb_rd;
    logic                   wb_reg_write;
    logic [`CPU_XLEN-1:0]   wb_value;

    modport producer (output mem_rd, mem_reg_write, mem_is_load, mem_value,
                      output wb_rd, wb_reg_write, wb_value);
    modport consumer (input mem_rd, mem_reg_write, mem_is_load, mem_value,
                      input wb_rd, wb_reg_write, wb_value);

endinterface

`default_nettype wire

/* source/fetch_unit.sv */
// fetch_unit
// word PC, loadable instruction memory and the fetch/decode register

`timescale 1ns/10ps
`default_nettype none

`include "cpu_consts.svh"

module fetch_unit
(
    input  logic                                SYS_clk,
    input  logic                                SYS_reset,
    input  logic                                load_en,
    input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  load_addr,
    input  logic [`CPU_XLEN-1:0]                load_data,
    output logic [`CPU_XLEN-1:0]                instr
);
    localparam int PC_W = $clog2(`CPU_IMEM_DEPTH);

    logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];
    logic [PC_W-1:0]      pc;  // word index, no byte offset

    // program load from outside, usually held in reset meanwhile
    always_ff @(posedge SYS_clk)
    begin
        if (load_en)
            imem[load_addr] <= load_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc    <= '0;
            instr <= '0;  // all-zero word writes r0 only
        end
        else
        begin
            pc    <= pc + 1'b1;  // no branches, always sequential
            instr <= imem[pc];
        end
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// decode_stage
// control decode, destination pick and sign extension into the decode/execute register

`timescale 1ns/10ps
`default_nettype none

`include "cpu_consts.svh"

module decode_stage
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic [`CPU_XLEN-1:0]   instr,
    output cpu_isa_pkg::reg_idx_t  rs_addr,
    output cpu_isa_pkg::reg_idx_t  rt_addr,
    input  logic [`CPU_XLEN-1:0]   rs_value,
    input  logic [`CPU_XLEN-1:0]   rt_value,
    output cpu_pipe_pkg::id_ex_t   id_ex
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    ctrl_t                ctrl;
    reg_idx_t             dest;
    logic [`CPU_XLEN-1:0] imm_ext;

    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];

    always_comb
    begin
        ctrl = '0;  // unknown encodings write nothing
        case (opcode_e'(instr[31:26]))
            OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.uses_rt   = 1'b1;
                case (funct_e'(instr[5:0]))
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl = '0;
                endcase
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;  // base + offset
            end
            OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.uses_rt     = 1'b1;  // rt is the store data
            end
            default: ctrl = '0;
        endcase
    end

    assign dest    = (opcode_e'(instr[31:26]) == OP_RTYPE) ? instr[15:11] : instr[20:16];
    assign imm_ext = {{(`CPU_XLEN-16){instr[15]}}, instr[15:0]};

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            id_ex <= '0;
        else
        begin
            id_ex.ctrl     <= ctrl;
            id_ex.rs       <= rs_addr;
            id_ex.rt       <= rt_addr;
            id_ex.rd       <= dest;
            id_ex.rs_value <= rs_value;
            id_ex.rt_value <= rt_value;
            id_ex.imm      <= imm_ext;
        end
    end

endmodule

`default_nettype wire

/* source/register_file.sv */
// register_file
// 32 registers, two decode reads and a debug read, written from write-back

`timescale 1ns/10ps
`default_nettype none

`include "cpu_consts.svh"

module register_file
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  cpu_isa_pkg::reg_idx_t  rs_addr,
    input  cpu_isa_pkg::reg_idx_t  rt_addr,
    output logic [`CPU_XLEN-1:0]   rs_value,
    output logic [`CPU_XLEN-1:0]   rt_value,
    input  cpu_isa_pkg::reg_idx_t  dbg_sel,
    output logic [`CPU_XLEN-1:0]   dbg_value,
    fwd_if.consumer                wb_port
);
    import cpu_isa_pkg::*;

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
    logic                 wr_en;
    reg_idx_t             wr_idx;
    logic [`CPU_XLEN-1:0] wr_data;

    assign wr_en   = wb_port.wb_reg_write && (wb_port.wb_rd != '0);  // r0 stays zero
    assign wr_idx  = wb_port.wb_rd;
    assign wr_data = wb_port.wb_value;

    // bypass the write in flight so decode sees it this cycle
    function automatic logic [`CPU_XLEN-1:0] read_port(input reg_idx_t addr);
        if (wr_en && (wr_idx == addr))
            return wr_data;
        return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_idx] <= wr_data;
    end

    always_comb
    begin
        rs_value  = read_port(rs_addr);
        rt_value  = read_port(rt_addr);
        dbg_value = read_port(dbg_sel);
    end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// execute_stage
// operand forwarding, ALU and the execute/memory register

`timescale 1ns/10ps
`default_nettype none

`include "cpu_consts.svh"

module execute_stage
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  cpu_pipe_pkg::id_ex_t   id_ex,
    fwd_if.consumer                fwd,
    output cpu_pipe_pkg::ex_mem_t  ex_mem
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic                 mem_ok;
    logic                 wb_ok;
    fwd_sel_e             rs_sel;
    fwd_sel_e             rt_sel;
    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] rt_fwd;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_result;

    // memory stage wins over write-back
    function automatic fwd_sel_e pick_fwd(input reg_idx_t src, input logic m_ok,
                                          input reg_idx_t m_rd, input logic w_ok,
                                          input reg_idx_t w_rd);
        if (m_ok && (m_rd == src))
            return FWD_MEM;
        if (w_ok && (w_rd == src))
            return FWD_WB;
        return FWD_NONE;
    endfunction

    function automatic logic [`CPU_XLEN-1:0] fwd_value(input fwd_sel_e sel,
                                                       input logic [`CPU_XLEN-1:0] dec,
                                                       input logic [`CPU_XLEN-1:0] m_val,
                                                       input logic [`CPU_XLEN-1:0] w_val);
        case (sel)
            FWD_MEM: return m_val;
            FWD_WB:  return w_val;
            default: return dec;
        endcase
    endfunction

    // a load in memory stage has no data yet, program must not depend on it
    assign mem_ok = fwd.mem_reg_write && !fwd.mem_is_load && (fwd.mem_rd != '0);
    assign wb_ok  = fwd.wb_reg_write && (fwd.wb_rd != '0);

    assign rs_sel = pick_fwd(id_ex.rs, mem_ok, fwd.mem_rd, wb_ok, fwd.wb_rd);
    assign rt_sel = id_ex.ctrl.uses_rt ? pick_fwd(id_ex.rt, mem_ok, fwd.mem_rd, wb_ok, fwd.wb_rd)
                                       : FWD_NONE;

    assign op_a   = fwd_value(rs_sel, id_ex.rs_value, fwd.mem_value, fwd.wb_value);
    assign rt_fwd = fwd_value(rt_sel, id_ex.rt_value, fwd.mem_value, fwd.wb_value);
    assign op_b   = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_fwd;

    always_comb
    begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {{(`CPU_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            ex_mem <= '0;
        else
        begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= rt_fwd;  // forwarded rt for sw
        end
    end

endmodule

`default_nettype wire

/* source/mem_wb_stage.sv */
// mem_wb_stage
// data memory, memory/write-back register and write-back select

`timescale 1ns/10ps
`default_nettype none

`include "cpu_consts.svh"

module mem_wb_stage
(
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  cpu_pipe_pkg::ex_mem_t  ex_mem,
    fwd_if.producer                fwd
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam int DA_W = $clog2(`CPU_DMEM_DEPTH);

    logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_DEPTH];
    logic [DA_W-1:0]      dmem_addr;
    logic [`CPU_XLEN-1:0] load_data;
    ctrl_t                wb_ctrl;
    reg_idx_t             wb_rd;
    logic [`CPU_XLEN-1:0] wb_load;
    logic [`CPU_XLEN-1:0] wb_alu;

    assign dmem_addr = ex_mem.alu_result[DA_W-1:0];  // word index
    assign load_data = dmem[dmem_addr];

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem.ctrl.mem_write)
            dmem[dmem_addr] <= ex_mem.store_data;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_ctrl <= '0;
            wb_rd   <= '0;
        end
        else
        begin
            wb_ctrl <= ex_mem.ctrl;
            wb_rd   <= ex_mem.rd;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_load <= load_data;
        wb_alu  <= ex_mem.alu_result;
    end

    // memory stage view, alu result only
    assign fwd.mem_rd        = ex_mem.rd;
    assign fwd.mem_reg_write = ex_mem.ctrl.reg_write;
    assign fwd.mem_is_load   = ex_mem.ctrl.mem_to_reg;
    assign fwd.mem_value     = ex_mem.alu_result;

    assign fwd.wb_rd         = wb_rd;
    assign fwd.wb_reg_write  = wb_ctrl.reg_write;
    assign fwd.wb_value      = wb_ctrl.mem_to_reg ? wb_load : wb_alu;

endmodule

`default_nettype wire

/* source/mips_pipeline.sv */
// mips_pipeline
// five stage integer pipeline with program load and register debug ports

`timescale 1ns/10ps
`default_nettype none

`include "cpu_consts.svh"

module mips_pipeline
(
    input  logic                                SYS_clk,
    input  logic                                SYS_reset,
    input  logic                                load_en,
    input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  load_addr,
    input  logic [`CPU_XLEN-1:0]                load_data,
    input  cpu_isa_pkg::reg_idx_t               dbg_sel,
    output logic [`CPU_XLEN-1:0]                dbg_value
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [`CPU_XLEN-1:0] instr;     // fetch/decode register
    reg_idx_t             rs_addr;
    reg_idx_t             rt_addr;
    logic [`CPU_XLEN-1:0] rs_value;
    logic [`CPU_XLEN-1:0] rt_value;
    id_ex_t               id_ex;
    ex_mem_t              ex_mem;

    fwd_if fwd_bus ();  // also feeds the register file write port

    fetch_unit u_fetch (.SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .load_en(load_en),
                        .load_addr(load_addr), .load_data(load_data), .instr(instr));

    decode_stage u_decode (.SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .instr(instr),
                           .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_value(rs_value),
                           .rt_value(rt_value), .id_ex(id_ex));

    register_file u_regs (.SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .rs_addr(rs_addr),
                          .rt_addr(rt_addr), .rs_value(rs_value), .rt_value(rt_value),
                          .dbg_sel(dbg_sel), .dbg_value(dbg_value), .wb_port(fwd_bus));

    execute_stage u_execute (.SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .id_ex(id_ex),
                             .fwd(fwd_bus), .ex_mem(ex_mem));

    mem_wb_stage u_mem_wb (.SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .ex_mem(ex_mem),
                           .fwd(fwd_bus));

endmodule

`default_nettype wire

/* bench/mips_chk.sv */
// mips_chk
// pipeline rule checks on the execute stage, bound into execute_stage

`timescale 1ns/10ps
`default_nettype none

module mips_chk
(
    input logic                    SYS_clk,
    input logic                    SYS_reset,
    input cpu_pipe_pkg::id_ex_t    id_ex,
    input cpu_pipe_pkg::ex_mem_t   ex_mem,
    input cpu_pipe_pkg::fwd_sel_e  rs_sel,
    input cpu_pipe_pkg::fwd_sel_e  rt_sel
);
    import cpu_pipe_pkg::*;

    logic load_use;
    logic any_write;

    // load in memory stage feeding the instruction right behind it
    assign load_use = ex_mem.ctrl.reg_write && ex_mem.ctrl.mem_to_reg && (ex_mem.rd != '0)
                      && ((ex_mem.rd == id_ex.rs)
                          || (id_ex.ctrl.uses_rt && (ex_mem.rd == id_ex.rt)));

    assign any_write = id_ex.ctrl.reg_write || id_ex.ctrl.mem_write
                       || ex_mem.ctrl.reg_write || ex_mem.ctrl.mem_write;

    no_load_use: assert property (@(posedge SYS_clk) disable iff (SYS_reset) !load_use)
        else $error("load result used by the next instruction");

    rs_fwd_nonzero: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
                                     (rs_sel != FWD_NONE) |-> (id_ex.rs != '0))
        else $error("rs forwarded from register 0");

    rt_fwd_nonzero: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
                                     (rt_sel != FWD_NONE) |-> (id_ex.rt != '0))
        else $error("rt forwarded from register 0");

    // stage registers cleared by the reset edge
    reset_quiet: assert property (@(posedge SYS_clk) !$past(SYS_reset) || !any_write)
        else $error("write control active after a reset edge");

endmodule

bind execute_stage mips_chk u_chk (.SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .id_ex(id_ex),
                                   .ex_mem(ex_mem), .rs_sel(rs_sel), .rt_sel(rt_sel));

`default_nettype wire

/* bench/tb_mips.sv */
// tb_mips
// loads table-driven programs into the pipeline and checks registers over the debug port

`timescale 1ns/10ps
`default_nettype none

module tb_mips;

    localparam int          NTESTS   = 7;
    localparam int          MAXW     = 12;
    localparam logic [5:0]  OPC_ADDI = 6'h08;
    localparam logic [5:0]  OPC_LW   = 6'h23;
    localparam logic [5:0]  OPC_SW   = 6'h2b;
    localparam logic [5:0]  F_ADD    = 6'h20;
    localparam logic [5:0]  F_SUB    = 6'h22;
    localparam logic [5:0]  F_AND    = 6'h24;
    localparam logic [5:0]  F_OR     = 6'h25;
    localparam logic [5:0]  F_SLT    = 6'h2a;
    localparam logic [31:0] NOP      = 32'h0;  // all-zero word, writes nothing

    logic        SYS_clk;
    logic        SYS_reset;
    logic        load_en;
    logic [5:0]  load_addr;
    logic [31:0] load_data;
    logic [4:0]  dbg_sel;
    logic [31:0] dbg_value;

    logic [31:0] prog [NTESTS][MAXW];
    int          prog_len [NTESTS];
    int          n_chk [NTESTS];
    logic [4:0]  chk_reg [NTESTS][4];
    logic [31:0] chk_val [NTESTS][4];
    string       test_name [NTESTS];
    logic [31:0] rng;
    int          cycle_count;
    int          cycle_limit = 0;  // zero until the table is built
    int          pass_count;
    int          fail_count;

    mips_pipeline DUT (.SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .load_en(load_en),
                       .load_addr(load_addr), .load_data(load_data), .dbg_sel(dbg_sel),
                       .dbg_value(dbg_value));

    initial
    begin
        SYS_clk = 1'b0;
        forever #50 SYS_clk = ~SYS_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic draw(output logic [15:0] v);
        rng = xorshift32(rng);
        v   = rng[15:0];
    endtask

    task automatic put_word(input int t, input logic [31:0] w);
        prog[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic expect_reg(input int t, input logic [4:0] r, input logic [31:0] v);
        chk_reg[t][n_chk[t]] = r;
        chk_val[t][n_chk[t]] = v;
        n_chk[t]++;
    endtask

    task automatic advance();
        @(posedge SYS_clk);
        #5;
    endtask

    task automatic build_table();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [31:0] r1v;
        logic [31:0] r2v;
        logic [31:0] r3v;
        int          sum;
        for (int t = 0; t < NTESTS; t++)
        begin
            prog_len[t] = 0;
            n_chk[t]    = 0;
        end
        // independent operands, three bubbles before use
        test_name[0] = "alu ops";
        draw(a);
        draw(b);
        put_word(0, i_type(OPC_ADDI, 5'd1, 5'd0, a));
        put_word(0, i_type(OPC_ADDI, 5'd2, 5'd0, b));
        repeat (3) put_word(0, NOP);
        put_word(0, r_type(F_ADD, 5'd3, 5'd1, 5'd2));
        put_word(0, r_type(F_SUB, 5'd4, 5'd1, 5'd2));
        put_word(0, r_type(F_AND, 5'd5, 5'd1, 5'd2));
        put_word(0, r_type(F_OR, 5'd6, 5'd1, 5'd2));
        expect_reg(0, 5'd3, sext16(a) + sext16(b));
        expect_reg(0, 5'd4, sext16(a) - sext16(b));
        expect_reg(0, 5'd5, sext16(a) & sext16(b));
        expect_reg(0, 5'd6, sext16(a) | sext16(b));
        test_name[1] = "signed slt";
        draw(a);
        a = a | 16'h8000;  // negative
        draw(b);
        b = b & 16'h7fff;  // positive
        put_word(1, i_type(OPC_ADDI, 5'd1, 5'd0, a));
        put_word(1, i_type(OPC_ADDI, 5'd2, 5'd0, b));
        repeat (3) put_word(1, NOP);
        put_word(1, r_type(F_SLT, 5'd3, 5'd1, 5'd2));
        put_word(1, r_type(F_SLT, 5'd4, 5'd2, 5'd1));
        put_word(1, r_type(F_SLT, 5'd5, 5'd1, 5'd1));
        expect_reg(1, 5'd1, sext16(a));
        expect_reg(1, 5'd3, 32'd1);  // negative below positive
        expect_reg(1, 5'd4, 32'd0);
        expect_reg(1, 5'd5, 32'd0);
        test_name[2] = "mem forward";
        draw(a);
        draw(b);
        put_word(2, i_type(OPC_ADDI, 5'd1, 5'd0, a));
        put_word(2, i_type(OPC_ADDI, 5'd2, 5'd1, b));
        put_word(2, r_type(F_ADD, 5'd3, 5'd2, 5'd1));
        put_word(2, r_type(F_SUB, 5'd4, 5'd3, 5'd2));
        r1v = sext16(a);
        r2v = r1v + sext16(b);
        r3v = r2v + r1v;
        expect_reg(2, 5'd1, r1v);
        expect_reg(2, 5'd2, r2v);
        expect_reg(2, 5'd3, r3v);
        expect_reg(2, 5'd4, r3v - r2v);
        test_name[3] = "wb and write-through";
        draw(a);
        draw(b);
        draw(c);
        put_word(3, i_type(OPC_ADDI, 5'd1, 5'd0, a));
        put_word(3, i_type(OPC_ADDI, 5'd5, 5'd0, c));
        put_word(3, r_type(F_ADD, 5'd2, 5'd1, 5'd1));  // distance two
        put_word(3, i_type(OPC_ADDI, 5'd3, 5'd0, b));
        repeat (2) put_word(3, NOP);
        put_word(3, r_type(F_SUB, 5'd4, 5'd3, 5'd2));  // distance three on r3
        r2v = sext16(a) + sext16(a);
        expect_reg(3, 5'd2, r2v);
        expect_reg(3, 5'd3, sext16(b));
        expect_reg(3, 5'd4, sext16(b) - r2v);
        expect_reg(3, 5'd5, sext16(c));
        test_name[4] = "negative imm";
        draw(a);
        draw(b);
        draw(c);
        a = a | 16'h8000;
        b = b | 16'h8000;
        c = c | 16'h8000;
        put_word(4, i_type(OPC_ADDI, 5'd1, 5'd0, a));
        put_word(4, i_type(OPC_ADDI, 5'd2, 5'd0, b));
        put_word(4, i_type(OPC_ADDI, 5'd3, 5'd1, c));
        put_word(4, i_type(OPC_ADDI, 5'd4, 5'd0, 16'hffff));
        expect_reg(4, 5'd1, sext16(a));
        expect_reg(4, 5'd2, sext16(b));
        expect_reg(4, 5'd3, sext16(a) + sext16(c));
        expect_reg(4, 5'd4, 32'hffff_ffff);
        test_name[5] = "store then load";
        draw(a);
        a = a & 16'h001f;  // base word index
        draw(b);
        draw(c);
        put_word(5, i_type(OPC_ADDI, 5'd1, 5'd0, a));
        put_word(5, i_type(OPC_ADDI, 5'd2, 5'd0, b));
        put_word(5, i_type(OPC_SW, 5'd2, 5'd1, 16'd3));
        put_word(5, i_type(OPC_ADDI, 5'd5, 5'd0, c));  // unrelated
        put_word(5, i_type(OPC_LW, 5'd3, 5'd1, 16'd3));
        put_word(5, NOP);
        put_word(5, r_type(F_ADD, 5'd4, 5'd3, 5'd3));
        expect_reg(5, 5'd3, sext16(b));
        expect_reg(5, 5'd4, sext16(b) + sext16(b));
        expect_reg(5, 5'd5, sext16(c));
        test_name[6] = "r0 stays zero";
        draw(a);
        draw(b);
        put_word(6, i_type(OPC_ADDI, 5'd0, 5'd0, a));
        put_word(6, r_type(F_ADD, 5'd1, 5'd0, 5'd0));
        put_word(6, i_type(OPC_ADDI, 5'd2, 5'd0, b));
        put_word(6, r_type(F_ADD, 5'd0, 5'd2, 5'd2));
        put_word(6, r_type(F_ADD, 5'd4, 5'd0, 5'd2));
        expect_reg(6, 5'd0, 32'd0);
        expect_reg(6, 5'd1, 32'd0);
        expect_reg(6, 5'd2, sext16(b));
        expect_reg(6, 5'd4, sext16(b));
        sum = 0;
        for (int t = 0; t < NTESTS; t++)
            sum += 16 + 64 + prog_len[t] + 6 + n_chk[t];
        cycle_limit = 2 * sum;
    endtask

    task automatic run_test(input int t);
        int errs;
        int w;
        int k;
        errs      = 0;
        SYS_reset = 1'b1;
        for (w = 0; w < 64; w++)
        begin
            load_en   = 1'b1;
            load_addr = w[5:0];
            load_data = (w < prog_len[t]) ? prog[t][w] : NOP;
            advance();
        end
        load_en = 1'b0;
        repeat (16) advance();
        SYS_reset = 1'b0;
        repeat (prog_len[t] + 6) advance();  // last result written by now
        for (k = 0; k < n_chk[t]; k++)
        begin
            dbg_sel = chk_reg[t][k];
            @(negedge SYS_clk);
            if (dbg_value !== chk_val[t][k])
            begin
                $display("error test %0d dbg_value r%0d expected %08h got %08h",
                         t, chk_reg[t][k], chk_val[t][k], dbg_value);
                errs++;
            end
            advance();
        end
        if (errs == 0)
        begin
            pass_count++;
            $display("test %0d %s: pass", t, test_name[t]);
        end
        else
        begin
            fail_count++;
            $display("test %0d %s: fail, %0d wrong", t, test_name[t], errs);
        end
    endtask

    initial
    begin
        cycle_count = 0;
        @(posedge SYS_clk);
        while (cycle_limit == 0 || cycle_count < cycle_limit)
        begin
            @(posedge SYS_clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        SYS_reset  = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        dbg_sel    = '0;
        rng        = 32'd68;
        pass_count = 0;
        fail_count = 0;
        build_table();
        advance();
        for (int t = 0; t < NTESTS; t++)
            run_test(t);
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/fwd_if.sv
source/fetch_unit.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/mips_pipeline.sv
bench/mips_chk.sv
bench/tb_mips.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mips -f flist.f -o sim_tb_mips
output=$(./obj_dir/sim_tb_mips)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
